// ==== hw/core_pkg.sv ====
// Shared widths, encodings and enums for the single-issue RV32I subset core
// Only ADDI, ADD, SUB, AND, OR, XOR, LUI and WFI are recognized
// Every other encoding is reported as an illegal instruction

package core_pkg;

    ////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////

    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;
    localparam int REG_IDX_W = $clog2(REG_COUNT);

    // Fetch address after reset, byte step per instruction
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
    localparam logic [XLEN-1:0] PC_STEP  = 32'd4;

    // Instruction buffer
    localparam int IB_DEPTH = 2;
    localparam int IB_PTR_W = (IB_DEPTH > 1) ? $clog2(IB_DEPTH) : 1;
    localparam int IB_CNT_W = $clog2(IB_DEPTH + 1);

    ////////////////////////////////////////
    // RV32I field encodings
    ////////////////////////////////////////

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // Full WFI word, matched as a whole
    localparam logic [XLEN-1:0] WFI_INST = 32'h1050_0073;

    // Executed operations
    typedef enum logic [2:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LUI, OP_HALT, OP_ILLEGAL
    } alu_op_t;

    // Core status, RISC-V exception code values
    typedef enum logic [3:0] {
        ILLEGAL_INST  = 4'h2,
        NO_ERROR      = 4'ha,
        HALTED_ON_WFI = 4'he
    } exec_status_t;

endpackage

// ==== hw/fetch_unit.sv ====
// Wishbone classic read master for instruction fetch
// One request outstanding at most; cyc and stb are driven together
// A new request starts only while the buffer reports room (full low)
// Address is held from the rise of cyc until the ack cycle

`timescale 1ns/1ps

module fetch_unit import core_pkg::*; (
    input  logic            clock,
    input  logic            reset,

    // Wishbone classic, read only
    input  logic            wb_ack,
    input  logic [XLEN-1:0] wb_dat,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic [XLEN-1:0] wb_adr,

    // Instruction buffer side
    input  logic            full,
    output logic            push,
    output logic [XLEN-1:0] push_inst,
    output logic [XLEN-1:0] push_npc
);

    ////////////////////////////////////////
    // Request state and program counter
    ////////////////////////////////////////

    logic            req;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] next_pc;

    assign next_pc = pc + PC_STEP;

    always_ff @(posedge clock) begin
        if (reset) begin
            req <= 1'b0;
            pc  <= RESET_PC;
        end else if (!req) begin
            // Open a cycle once the buffer can take the word
            if (!full) begin
                req <= 1'b1;
            end
        end else if (wb_ack) begin
            // Word taken this cycle, cyc drops at this edge
            req <= 1'b0;
            pc  <= next_pc;
        end
    end

    ////////////////////////////////////////
    // Bus and push outputs
    ////////////////////////////////////////

    assign wb_cyc = req;
    assign wb_stb = req;

    // PC only moves on ack, so the address is stable for the whole cycle
    assign wb_adr = pc;

    // One-cycle strobe in the ack cycle
    assign push      = req && wb_ack;
    assign push_inst = wb_dat;
    assign push_npc  = next_pc;

endmodule

// ==== hw/insn_buffer.sv ====
// Circular FIFO between fetch and dispatch, IB_DEPTH entries
// full counts an outstanding fetch as an entry, so a started request
// always finds room when it completes

`timescale 1ns/1ps

module insn_buffer import core_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  logic            push,
    input  logic [XLEN-1:0] push_inst,
    input  logic [XLEN-1:0] push_npc,
    input  logic            pending,
    input  logic            pop,
    output logic            full,
    output logic            head_valid,
    output logic [XLEN-1:0] head_inst,
    output logic [XLEN-1:0] head_npc
);

    // Entry storage
    logic [XLEN-1:0] inst_mem [IB_DEPTH];
    logic [XLEN-1:0] npc_mem  [IB_DEPTH];

    logic [IB_PTR_W-1:0] wr_ptr;
    logic [IB_PTR_W-1:0] rd_ptr;
    logic [IB_CNT_W-1:0] count;

    function automatic logic [IB_PTR_W-1:0] ptr_inc(input logic [IB_PTR_W-1:0] ptr);
        return (ptr == IB_PTR_W'(IB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clock) begin
        if (push) begin
            inst_mem[wr_ptr] <= push_inst;
            npc_mem[wr_ptr]  <= push_npc;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // Push and pop in one cycle leave count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // One spare bit so count plus pending cannot wrap
    assign full = ({1'b0, count} + (IB_CNT_W + 1)'(pending)) >= (IB_CNT_W + 1)'(IB_DEPTH);

    assign head_valid = (count != '0);
    assign head_inst  = inst_mem[rd_ptr];
    assign head_npc   = npc_mem[rd_ptr];

endmodule

// ==== hw/decode_dispatch.sv ====
// Decodes the buffer head and issues it in the same cycle
// At most one instruction per cycle, none after a halting one issues
// Operands come straight from the register file, no bypass

`timescale 1ns/1ps

module decode_dispatch import core_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,

    // Buffer head
    input  logic                 head_valid,
    input  logic [XLEN-1:0]      head_inst,
    input  logic [XLEN-1:0]      head_npc,
    output logic                 pop,

    // Register file read ports
    output logic [REG_IDX_W-1:0] rs1_idx,
    output logic [REG_IDX_W-1:0] rs2_idx,
    input  logic [XLEN-1:0]      rs1_data,
    input  logic [XLEN-1:0]      rs2_data,

    // To execute
    input  logic                 halted,
    output logic                 issue,
    output alu_op_t              op,
    output logic [REG_IDX_W-1:0] rd_idx,
    output logic [XLEN-1:0]      operand_a,
    output logic [XLEN-1:0]      operand_b,
    output logic [XLEN-1:0]      issue_npc
);

    ////////////////////////////////////////
    // Field split
    ////////////////////////////////////////

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic            stop_q;

    assign opcode  = head_inst[6:0];
    assign funct3  = head_inst[14:12];
    assign funct7  = head_inst[31:25];
    assign rd_idx  = head_inst[11:7];
    assign rs1_idx = head_inst[19:15];
    assign rs2_idx = head_inst[24:20];

    // Sign-extended I immediate, U immediate in the upper bits
    assign imm_i = {{(XLEN - 12){head_inst[31]}}, head_inst[31:20]};
    assign imm_u = {head_inst[31:12], 12'b0};

    // Opcode map, anything unmatched is illegal
    always_comb begin
        op = OP_ILLEGAL;
        if (head_inst == WFI_INST) begin
            op = OP_HALT;
        end else if (opcode == OPC_LUI) begin
            op = OP_LUI;
        end else if (opcode == OPC_OP_IMM && funct3 == F3_ADD_SUB) begin
            op = OP_ADD;
        end else if (opcode == OPC_OP && funct7 == F7_SUB && funct3 == F3_ADD_SUB) begin
            op = OP_SUB;
        end else if (opcode == OPC_OP && funct7 == F7_BASE) begin
            case (funct3)
                F3_ADD_SUB: op = OP_ADD;
                F3_XOR:     op = OP_XOR;
                F3_OR:      op = OP_OR;
                F3_AND:     op = OP_AND;
                default:    op = OP_ILLEGAL;
            endcase
        end
    end

    // Register form takes rs2, immediate forms take their immediate
    assign operand_a = rs1_data;
    assign operand_b = (opcode == OPC_OP)  ? rs2_data :
                       (opcode == OPC_LUI) ? imm_u    : imm_i;
    assign issue_npc = head_npc;

    ////////////////////////////////////////
    // Issue gating
    ////////////////////////////////////////

    // Set at the edge a halting op issues, so the next head is held back
    always_ff @(posedge clock) begin
        if (reset) begin
            stop_q <= 1'b0;
        end else if (halted || (issue && (op == OP_HALT || op == OP_ILLEGAL))) begin
            stop_q <= 1'b1;
        end
    end

    assign issue = head_valid && !stop_q;
    assign pop   = issue;

endmodule

// ==== hw/reg_file.sv ====
// Architectural registers, two combinational reads, one write
// Register zero is never written by execute, so it reads zero after reset

`timescale 1ns/1ps

module reg_file import core_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  logic [REG_IDX_W-1:0] rs1_idx,
    input  logic [REG_IDX_W-1:0] rs2_idx,
    output logic [XLEN-1:0]      rs1_data,
    output logic [XLEN-1:0]      rs2_data,
    input  logic                 wr_en,
    input  logic [REG_IDX_W-1:0] wr_idx,
    input  logic [XLEN-1:0]      wr_data
);

    logic [XLEN-1:0] regs [REG_COUNT];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

endmodule

// ==== hw/execute_commit.sv ====
// Single-cycle ALU and commit register
// The register write happens at the issue edge, commit outputs show it
// one cycle later; a halting op commits without a write and stops the core

`timescale 1ns/1ps

module execute_commit import core_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 issue,
    input  alu_op_t              op,
    input  logic [REG_IDX_W-1:0] rd_idx,
    input  logic [XLEN-1:0]      operand_a,
    input  logic [XLEN-1:0]      operand_b,
    input  logic [XLEN-1:0]      issue_npc,

    // Register file write port
    output logic                 wr_en,
    output logic [REG_IDX_W-1:0] wr_idx,
    output logic [XLEN-1:0]      wr_data,

    output logic                 halted,
    output logic                 commit_valid,
    output logic                 commit_wr_en,
    output logic [REG_IDX_W-1:0] commit_wr_idx,
    output logic [XLEN-1:0]      commit_wr_data,
    output logic [XLEN-1:0]      commit_npc,
    output exec_status_t         error_status
);

    logic [XLEN-1:0] result;
    logic            is_halt;

    always_comb begin
        case (op)
            OP_ADD:  result = operand_a + operand_b;
            OP_SUB:  result = operand_a - operand_b;
            OP_AND:  result = operand_a & operand_b;
            OP_OR:   result = operand_a | operand_b;
            OP_XOR:  result = operand_a ^ operand_b;
            OP_LUI:  result = operand_b;
            default: result = '0;
        endcase
    end

    assign is_halt = (op == OP_HALT) || (op == OP_ILLEGAL);

    // No write for halting ops or rd of zero
    assign wr_en   = issue && !is_halt && (rd_idx != '0);
    assign wr_idx  = rd_idx;
    assign wr_data = result;

    ////////////////////////////////////////
    // Commit register and status
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            commit_valid <= 1'b0;
            commit_wr_en <= 1'b0;
            halted       <= 1'b0;
            error_status <= NO_ERROR;
        end else begin
            commit_valid <= issue;
            commit_wr_en <= wr_en;
            // Status sticks until the next reset
            if (issue && is_halt) begin
                halted       <= 1'b1;
                error_status <= (op == OP_HALT) ? HALTED_ON_WFI : ILLEGAL_INST;
            end
        end
    end

    // Payload fields that go with commit_valid
    always_ff @(posedge clock) begin
        if (issue) begin
            commit_wr_idx  <= rd_idx;
            commit_wr_data <= result;
            commit_npc     <= issue_npc;
        end
    end

endmodule

// ==== hw/core_top.sv ====
// Single-issue core: fetch, buffer, dispatch, register file, execute
// Instruction memory sits outside on a read-only Wishbone classic bus

`timescale 1ns/1ps

module core_top import core_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 wb_ack,
    input  logic [XLEN-1:0]      wb_dat,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic [XLEN-1:0]      wb_adr,
    output logic                 commit_valid,
    output logic                 commit_wr_en,
    output logic [REG_IDX_W-1:0] commit_wr_idx,
    output logic [XLEN-1:0]      commit_wr_data,
    output logic [XLEN-1:0]      commit_npc,
    output exec_status_t         error_status
);

    // Fetch to buffer
    logic            push;
    logic [XLEN-1:0] push_inst;
    logic [XLEN-1:0] push_npc;
    logic            full;

    // Buffer to dispatch
    logic            head_valid;
    logic [XLEN-1:0] head_inst;
    logic [XLEN-1:0] head_npc;
    logic            pop;

    // Dispatch, register file and execute
    logic [REG_IDX_W-1:0] rs1_idx;
    logic [REG_IDX_W-1:0] rs2_idx;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;
    logic                 issue;
    alu_op_t              op;
    logic [REG_IDX_W-1:0] rd_idx;
    logic [XLEN-1:0]      operand_a;
    logic [XLEN-1:0]      operand_b;
    logic [XLEN-1:0]      issue_npc;
    logic                 wr_en;
    logic [REG_IDX_W-1:0] wr_idx;
    logic [XLEN-1:0]      wr_data;
    logic                 halted;

    fetch_unit u_fetch_unit (
        .clock     (clock),
        .reset     (reset),
        .wb_ack    (wb_ack),
        .wb_dat    (wb_dat),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_adr    (wb_adr),
        .full      (full),
        .push      (push),
        .push_inst (push_inst),
        .push_npc  (push_npc)
    );

    // Open bus cycle counts as a pending entry
    insn_buffer u_insn_buffer (
        .clock      (clock),
        .reset      (reset),
        .push       (push),
        .push_inst  (push_inst),
        .push_npc   (push_npc),
        .pending    (wb_cyc),
        .pop        (pop),
        .full       (full),
        .head_valid (head_valid),
        .head_inst  (head_inst),
        .head_npc   (head_npc)
    );

    decode_dispatch u_decode_dispatch (
        .clock      (clock),
        .reset      (reset),
        .head_valid (head_valid),
        .head_inst  (head_inst),
        .head_npc   (head_npc),
        .pop        (pop),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .halted     (halted),
        .issue      (issue),
        .op         (op),
        .rd_idx     (rd_idx),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .issue_npc  (issue_npc)
    );

    reg_file u_reg_file (
        .clock    (clock),
        .reset    (reset),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data)
    );

    execute_commit u_execute_commit (
        .clock          (clock),
        .reset          (reset),
        .issue          (issue),
        .op             (op),
        .rd_idx         (rd_idx),
        .operand_a      (operand_a),
        .operand_b      (operand_b),
        .issue_npc      (issue_npc),
        .wr_en          (wr_en),
        .wr_idx         (wr_idx),
        .wr_data        (wr_data),
        .halted         (halted),
        .commit_valid   (commit_valid),
        .commit_wr_en   (commit_wr_en),
        .commit_wr_idx  (commit_wr_idx),
        .commit_wr_data (commit_wr_data),
        .commit_npc     (commit_npc),
        .error_status   (error_status)
    );

endmodule

// ==== tb/core_checker.sv ====
// Bound to core_top: Wishbone classic rules, reset values and the halt rule
// Failures raise $error and bump fail_count, which the testbench polls

`timescale 1ns/1ps

module core_checker import core_pkg::*; (
    input logic            clock,
    input logic            reset,
    input logic            wb_cyc,
    input logic            wb_stb,
    input logic            wb_ack,
    input logic [XLEN-1:0] wb_adr,
    input logic            commit_valid,
    input logic            commit_wr_en,
    input exec_status_t    error_status
);

    int              fail_count = 0;
    logic            acked_once;
    logic            committed_once;
    logic [XLEN-1:0] last_adr;

    // Last completed fetch address, first commit flag
    always_ff @(posedge clock) begin
        if (reset) begin
            acked_once     <= 1'b0;
            committed_once <= 1'b0;
            last_adr       <= '0;
        end else begin
            if (wb_cyc && wb_ack) begin
                acked_once <= 1'b1;
                last_adr   <= wb_adr;
            end
            if (commit_valid) begin
                committed_once <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Wishbone
    ////////////////////////////////////////

    a_stb_cyc: assert property (@(posedge clock) disable iff (reset)
        wb_stb == wb_cyc)
        else begin fail_count++; $error("wb_stb differs from wb_cyc"); end

    // Address held until the ack cycle
    a_adr_hold: assert property (@(posedge clock) disable iff (reset)
        wb_cyc && !wb_ack |=> wb_cyc && $stable(wb_adr))
        else begin fail_count++; $error("wb_adr or wb_cyc changed before ack"); end

    a_first_adr: assert property (@(posedge clock) disable iff (reset)
        $rose(wb_cyc) && !acked_once |-> wb_adr == RESET_PC)
        else begin fail_count++; $error("first fetch is not at the reset PC"); end

    a_adr_step: assert property (@(posedge clock) disable iff (reset)
        $rose(wb_cyc) && acked_once |-> wb_adr == last_adr + PC_STEP)
        else begin fail_count++; $error("fetch address did not step by one word"); end

    ////////////////////////////////////////
    // Reset values and halt
    ////////////////////////////////////////

    a_after_reset: assert property (@(posedge clock) disable iff (reset)
        $past(reset) |-> !wb_cyc && !commit_valid && !commit_wr_en)
        else begin fail_count++; $error("outputs not idle right after reset"); end

    a_before_commit: assert property (@(posedge clock) disable iff (reset)
        !committed_once && !commit_valid |-> !commit_wr_en && error_status == NO_ERROR)
        else begin fail_count++; $error("commit outputs active before the first commit"); end

    // Nothing commits once a status is latched
    a_halt: assert property (@(posedge clock) disable iff (reset)
        error_status != NO_ERROR |=> !commit_valid)
        else begin fail_count++; $error("commit after the core halted"); end

endmodule

// ==== tb/core_tb.sv ====
// Testbench for core_top with a Wishbone instruction memory model
// Memory answers after 0 to 3 random wait states, unmapped addresses read zero
// Two runs: a program ending in WFI, then the same image with one illegal word

`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

    localparam int CLK_HALF       = 4;
    localparam int RESET_CYCLES   = 4;
    localparam int PROG_LEN       = 12;
    localparam int SETTLE_CYCLES  = 24;
    localparam int QUIET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = 40 * PROG_LEN * 2 + 200;

    logic                 clock;
    logic                 reset;
    logic                 wb_ack;
    logic [XLEN-1:0]      wb_dat;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic [XLEN-1:0]      wb_adr;
    logic                 commit_valid;
    logic                 commit_wr_en;
    logic [REG_IDX_W-1:0] commit_wr_idx;
    logic [XLEN-1:0]      commit_wr_data;
    logic [XLEN-1:0]      commit_npc;
    exec_status_t         error_status;

    // Program image and reference model state
    logic [31:0] image [PROG_LEN];
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    bit          halt_seen;
    int          ack_total;
    int          halt_ack_base;
    int          waits_left;
    bit          busy;
    integer      seed;

    core_top dut (
        .clock          (clock),
        .reset          (reset),
        .wb_ack         (wb_ack),
        .wb_dat         (wb_dat),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_adr         (wb_adr),
        .commit_valid   (commit_valid),
        .commit_wr_en   (commit_wr_en),
        .commit_wr_idx  (commit_wr_idx),
        .commit_wr_data (commit_wr_data),
        .commit_npc     (commit_npc),
        .error_status   (error_status)
    );

    bind core_top core_checker u_checker (
        .clock        (clock),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_ack       (wb_ack),
        .wb_adr       (wb_adr),
        .commit_valid (commit_valid),
        .commit_wr_en (commit_wr_en),
        .error_status (error_status)
    );

    always #CLK_HALF clock = ~clock;

    ////////////////////////////////////////
    // Failure reporting
    ////////////////////////////////////////

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] observed);
        assert (observed === expected) else begin
            $display("CHECK FAILED at %0t: %s expected %h observed %h",
                     $time, name, expected, observed);
            stop_with_failure();
        end
    endtask

    ////////////////////////////////////////
    // Instruction encoders and image
    ////////////////////////////////////////

    function automatic logic [31:0] encode_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] encode_reg(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic load_program(input bit inject_illegal);
        image[0]  = encode_addi(5'd1, 5'd0, 12'd5);
        // Negative immediate, -3
        image[1]  = encode_addi(5'd2, 5'd0, 12'hffd);
        image[2]  = encode_reg(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2);
        image[3]  = encode_reg(7'b0100000, 3'b000, 5'd4, 5'd1, 5'd2);
        image[4]  = encode_lui(5'd5, 20'habcde);
        image[5]  = encode_reg(7'b0000000, 3'b111, 5'd6, 5'd5, 5'd2);
        image[6]  = encode_reg(7'b0000000, 3'b110, 5'd7, 5'd5, 5'd1);
        image[7]  = encode_reg(7'b0000000, 3'b100, 5'd8, 5'd7, 5'd2);
        // Write to x0 is dropped, then x0 is read back
        image[8]  = encode_addi(5'd0, 5'd1, 12'd7);
        image[9]  = encode_reg(7'b0000000, 3'b000, 5'd9, 5'd0, 5'd1);
        // Depends on the result just before
        image[10] = encode_addi(5'd10, 5'd9, 12'hfff);
        image[11] = 32'h1050_0073;
        if (inject_illegal) begin
            image[6] = 32'hffff_ffff;
        end
    endtask

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (addr[1:0] != 2'b00 || idx >= PROG_LEN) begin
            return 32'h0;
        end
        return image[idx];
    endfunction

    ////////////////////////////////////////
    // Wishbone memory model
    ////////////////////////////////////////

    always @(negedge clock) begin
        if (reset) begin
            wb_ack = 1'b0;
            busy   = 1'b0;
        end else if (wb_ack) begin
            // Ack lasts one cycle, cyc is already low
            wb_ack = 1'b0;
            busy   = 1'b0;
        end else if (wb_cyc) begin
            if (!busy) begin
                busy       = 1'b1;
                waits_left = int'($unsigned($random(seed)) % 4);
            end
            if (waits_left == 0) begin
                wb_ack = 1'b1;
                wb_dat = read_word(wb_adr);
            end else begin
                waits_left = waits_left - 1;
            end
        end
    end

    // Ack only changes on the falling edge
    always @(posedge clock) begin
        if (wb_ack) begin
            ack_total = ack_total + 1;
        end
    end

    ////////////////////////////////////////
    // Reference model and commit checks
    ////////////////////////////////////////

    task automatic check_commit();
        logic [31:0]  word;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  result;
        logic [6:0]   opc;
        logic [6:0]   f7;
        logic [2:0]   f3;
        logic [4:0]   rd;
        logic         writes;
        exec_status_t status;
        word   = read_word(model_pc);
        opc    = word[6:0];
        f3     = word[14:12];
        f7     = word[31:25];
        rd     = word[11:7];
        a      = model_regs[word[19:15]];
        b      = model_regs[word[24:20]];
        result = 32'h0;
        writes = 1'b1;
        status = NO_ERROR;
        if (word == 32'h1050_0073) begin
            status = HALTED_ON_WFI;
            writes = 1'b0;
        end else if (opc == 7'b0110111) begin
            result = {word[31:12], 12'h000};
        end else if (opc == 7'b0010011 && f3 == 3'b000) begin
            result = a + {{20{word[31]}}, word[31:20]};
        end else if (opc == 7'b0110011 && f7 == 7'b0100000 && f3 == 3'b000) begin
            result = a - b;
        end else if (opc == 7'b0110011 && f7 == 7'b0000000 && f3 == 3'b000) begin
            result = a + b;
        end else if (opc == 7'b0110011 && f7 == 7'b0000000 && f3 == 3'b111) begin
            result = a & b;
        end else if (opc == 7'b0110011 && f7 == 7'b0000000 && f3 == 3'b110) begin
            result = a | b;
        end else if (opc == 7'b0110011 && f7 == 7'b0000000 && f3 == 3'b100) begin
            result = a ^ b;
        end else begin
            status = ILLEGAL_INST;
            writes = 1'b0;
        end
        if (rd == 5'd0) begin
            writes = 1'b0;
        end
        // Program order shows up as the NPC sequence
        check_field("commit_npc", model_pc + 32'd4, commit_npc);
        check_field("commit_wr_en", 32'(writes), 32'(commit_wr_en));
        check_field("error_status", 32'(status), 32'(error_status));
        if (writes) begin
            check_field("commit_wr_idx", 32'(rd), 32'(commit_wr_idx));
            check_field("commit_wr_data", result, commit_wr_data);
            model_regs[rd] = result;
        end
        if (status != NO_ERROR) begin
            halt_seen     = 1'b1;
            halt_ack_base = ack_total;
        end
        model_pc = model_pc + 32'd4;
    endtask

    always @(negedge clock) begin
        if (!reset && commit_valid) begin
            if (halt_seen) begin
                $display("ERROR at %0t: a commit followed the halting instruction", $time);
                stop_with_failure();
            end else begin
                check_commit();
            end
        end
    end

    // Bound assertions count their failures
    always @(negedge clock) begin
        if (dut.u_checker.fail_count != 0) begin
            $display("ERROR at %0t: a bound protocol assertion failed", $time);
            stop_with_failure();
        end
    end

    ////////////////////////////////////////
    // Runs
    ////////////////////////////////////////

    task automatic run_program(input bit inject_illegal, input int halt_index,
                               input exec_status_t halt_status);
        load_program(inject_illegal);
        @(negedge clock);
        reset = 1'b1;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'h0;
        end
        model_pc  = RESET_PC;
        halt_seen = 1'b0;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        while (!halt_seen) begin
            @(negedge clock);
        end
        check_field("error_status", 32'(halt_status), 32'(error_status));
        check_field("halt_npc", 32'((halt_index + 1) * 4), model_pc);
        // Back-pressure window, then the bus must stay idle
        repeat (SETTLE_CYCLES) @(negedge clock);
        repeat (QUIET_CYCLES) begin
            @(negedge clock);
            check_field("wb_cyc", 32'h0, 32'(wb_cyc));
        end
        assert (ack_total - halt_ack_base <= IB_DEPTH + 1) else begin
            $display("ERROR at %0t: %0d fetch acks after the halt, limit %0d",
                     $time, ack_total - halt_ack_base, IB_DEPTH + 1);
            stop_with_failure();
        end
    endtask

    initial begin
        clock         = 1'b0;
        reset         = 1'b1;
        wb_ack        = 1'b0;
        wb_dat        = 32'h0;
        seed          = 69085;
        busy          = 1'b0;
        waits_left    = 0;
        ack_total     = 0;
        halt_ack_base = 0;
        halt_seen     = 1'b0;
        model_pc      = RESET_PC;
        run_program(1'b0, 11, HALTED_ON_WFI);
        run_program(1'b1, 6, ILLEGAL_INST);
        $display("Finished with no errors");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock);
        $display("ERROR at %0t: timeout, the core never halted", $time);
        stop_with_failure();
    end

endmodule

// ==== vlog.f ====
hw/core_pkg.sv
hw/fetch_unit.sv
hw/insn_buffer.sv
hw/decode_dispatch.sv
hw/reg_file.sv
hw/execute_commit.sv
hw/core_top.sv
tb/core_checker.sv
tb/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator; the log decides pass or fail
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f vlog.f
./obj_dir/Vcore_tb 2>&1 | tee sim.log
if grep -q "Finished with no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
